//--- build.f
+incdir+src
src/l2_trig_pkg.sv
src/l2_apb_pkg.sv
src/l2_apb_regs.sv
src/l2_sector_map.sv
src/l2_coincidence.sv
src/l2_master_trigger.sv
src/l2_meta_align.sv
src/l2_trigger_top.sv
tests/l2_trigger_asserts.sv
tests/tb_l2_trigger.sv

//--- src/l2_apb_pkg.sv
`default_nettype none

`include "l2_consts.svh"

package l2_apb_pkg;

    typedef logic [`L2_APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [`L2_APB_DATA_W-1:0] apb_data_t;

    // requester side of the bus
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    // completer side of the bus
    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // register map
    typedef enum apb_addr_t {
        REG_CTRL = `L2_ADDR_CTRL,
        REG_MASK = `L2_ADDR_MASK
    } l2_reg_e;

endpackage

`default_nettype wire

//--- src/l2_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_consts.svh"

module l2_apb_regs (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,
    input  wire l2_apb_pkg::apb_req_t apb_req_i,
    output l2_apb_pkg::apb_rsp_t      apb_rsp_o,
    output l2_trig_pkg::l2_cfg_t      cfg_o
);
    import l2_apb_pkg::*;
    import l2_trig_pkg::*;

    l2_cfg_t cfg_q;
    l2_reg_e reg_sel;
    logic    access;
    logic    hit_ctrl;
    logic    hit_mask;

    // access phase, no wait states
    assign access  = apb_req_i.psel && apb_req_i.penable;
    assign reg_sel = l2_reg_e'(apb_req_i.paddr);

    always_comb begin
        hit_ctrl = 1'b0;
        hit_mask = 1'b0;
        case (reg_sel)
            REG_CTRL: hit_ctrl = 1'b1;
            REG_MASK: hit_mask = 1'b1;
            default: begin
                hit_ctrl = 1'b0;
                hit_mask = 1'b0;
            end
        endcase
    end

    // writes land on the edge that closes the access phase
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cfg_q <= '0;
        end else if (access && apb_req_i.pwrite) begin
            if (hit_ctrl) begin
                cfg_q.rf_en      <= apb_req_i.pwdata[0];
                cfg_q.logic_type <= apb_req_i.pwdata[1];
            end
            if (hit_mask) begin
                cfg_q.mask <= apb_req_i.pwdata[$bits(cfg_q.mask)-1:0];
            end
        end
    end

    always_comb begin
        apb_rsp_o        = '0;
        apb_rsp_o.pready = 1'b1;
        if (access) begin
            if (hit_ctrl) begin
                apb_rsp_o.prdata[0] = cfg_q.rf_en;
                apb_rsp_o.prdata[1] = cfg_q.logic_type;
            end else if (hit_mask) begin
                apb_rsp_o.prdata = apb_data_t'(cfg_q.mask);
            end else begin
                // unmapped address, read data stays zero
                apb_rsp_o.pslverr = 1'b1;
            end
        end
    end

    assign cfg_o = cfg_q;

endmodule

`default_nettype wire

//--- src/l2_coincidence.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_consts.svh"

module l2_coincidence (
    input  wire logic                     clk_i,
    input  wire logic                     reset_i,
    input  wire l2_trig_pkg::pol_sectors_t sectors_i,
    input  wire l2_trig_pkg::sector_mask_t mask_i,
    input  wire logic                     logic_type_i,
    input  wire logic                     rf_en_i,
    output logic                          pol_hit_o,
    output l2_trig_pkg::sector_mask_t     scaler_o
);
    import l2_trig_pkg::*;

    pol_sectors_t sectors_q;
    pol_sectors_t stretched_q;
    sector_vec_t  high_rot;
    sector_vec_t  combined;
    sector_mask_t sect_hit;
    sector_mask_t sect_hit_q;
    sector_mask_t sect_hit_qq;

    // two-sample stretch, current OR previous
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sectors_q   <= '0;
            stretched_q <= '0;
        end else begin
            sectors_q        <= sectors_i;
            stretched_q.low  <= sectors_i.low | sectors_q.low;
            stretched_q.high <= sectors_i.high | sectors_q.high;
        end
    end

    // sector i meets the high pattern of sector i+1, 11 wraps to 0
    assign high_rot = {stretched_q.high[`L2_NREGION-1:0],
                       stretched_q.high[`L2_SECT_W-1:`L2_NREGION]};

    assign combined = logic_type_i ? (stretched_q.low | high_rot)
                                   : (stretched_q.low & high_rot);

    always_comb begin
        for (int i = 0; i < `L2_NSECT; i++) begin
            sect_hit[i] = |combined[`L2_NREGION*i +: `L2_NREGION];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sect_hit_q  <= '0;
            sect_hit_qq <= '0;
            pol_hit_o   <= 1'b0;
            scaler_o    <= '0;
        end else begin
            sect_hit_q  <= sect_hit;
            sect_hit_qq <= sect_hit_q;
            // mask only affects the trigger, not the scalers
            pol_hit_o   <= rf_en_i && |(sect_hit & ~mask_i);
            // one pulse per rising sector hit
            scaler_o    <= sect_hit_q & ~sect_hit_qq;
        end
    end

endmodule

`default_nettype wire

//--- src/l2_consts.svh
`ifndef L2_CONSTS_SVH
`define L2_CONSTS_SVH

// front-end concentrators and sector geometry
`define L2_NTIO       4
`define L2_NPOL       2
`define L2_NSECT      12
`define L2_NREGION    4
`define L2_SECT_W     48

// word widths coming from the concentrators
`define L2_META_W     64
`define L2_TRIG_W     8

// trigger word bit positions
`define L2_LF_BIT     6
`define L2_AUX_BIT    7

// pipeline depth from input sample to trig_o
`define L2_RF_LATENCY 4
// level-two hits are blocked this many cycles after reset
`define L2_POR_CYCLES 4

// register bus
`define L2_APB_ADDR_W 8
`define L2_APB_DATA_W 32
`define L2_ADDR_CTRL  8'h00
`define L2_ADDR_MASK  8'h04

`endif

//--- src/l2_master_trigger.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_consts.svh"

module l2_master_trigger (
    input  wire logic                      clk_i,
    input  wire logic                      reset_i,
    input  wire l2_trig_pkg::tio_trig_arr_t tio_trig_i,
    input  wire logic                      rf_en_i,
    input  wire logic [`L2_NPOL-1:0]       pol_hit_i,
    input  wire logic                      holdoff_i,
    input  wire logic                      dead_i,
    output logic                           trig_o
);
    // the final register adds the last stage
    localparam int SIDE_DELAY = `L2_RF_LATENCY - 1;
    localparam int POR_W      = $clog2(`L2_POR_CYCLES + 1);

    logic [`L2_NPOL-1:0]                lf_now;
    logic                               aux_now;
    // aux in the top bit, lf per polarization below
    logic [SIDE_DELAY-1:0][`L2_NPOL:0]  side_q;
    logic [`L2_NPOL:0]                  side_out;
    logic [POR_W-1:0]                   por_cnt;
    logic                               por_done;

    // lf of pol p comes from concentrators 2p and 2p+1
    always_comb begin
        for (int p = 0; p < `L2_NPOL; p++) begin
            lf_now[p] = rf_en_i && (tio_trig_i[2*p][`L2_LF_BIT] ||
                                    tio_trig_i[2*p+1][`L2_LF_BIT]);
        end
    end

    // aux ignores rf_en
    always_comb begin
        aux_now = 1'b0;
        for (int k = 0; k < `L2_NTIO; k++) begin
            aux_now = aux_now | tio_trig_i[k][`L2_AUX_BIT];
        end
    end

    // line up lf and aux with the pol hits of the same sample
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            side_q <= '0;
        end else begin
            side_q[0] <= {aux_now, lf_now};
            for (int s = 1; s < SIDE_DELAY; s++) begin
                side_q[s] <= side_q[s-1];
            end
        end
    end

    assign side_out = side_q[SIDE_DELAY-1];

    // power-on holdoff counter
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            por_cnt <= '0;
        end else if (!por_done) begin
            por_cnt <= por_cnt + 1'b1;
        end
    end

    assign por_done = (por_cnt == POR_W'(`L2_POR_CYCLES));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            trig_o <= 1'b0;
        end else begin
            trig_o <= !holdoff_i && !dead_i &&
                      (side_out[`L2_NPOL] || (|side_out[`L2_NPOL-1:0]) ||
                       (por_done && (|pol_hit_i)));
        end
    end

endmodule

`default_nettype wire

//--- src/l2_meta_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_consts.svh"

module l2_meta_align #(
    parameter int DEPTH = `L2_RF_LATENCY
) (
    input  wire logic                      clk_i,
    input  wire logic                      reset_i,
    input  wire l2_trig_pkg::tio_meta_arr_t tio_meta_i,
    output l2_trig_pkg::tio_meta_arr_t     tio_meta_o
);
    import l2_trig_pkg::*;

    // whole metadata sets shift together
    tio_meta_arr_t [DEPTH-1:0] meta_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            meta_q <= '0;
        end else begin
            meta_q[0] <= tio_meta_i;
            for (int k = 1; k < DEPTH; k++) begin
                meta_q[k] <= meta_q[k-1];
            end
        end
    end

    assign tio_meta_o = meta_q[DEPTH-1];

endmodule

`default_nettype wire

//--- src/l2_sector_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_consts.svh"

module l2_sector_map (
    input  wire logic                      clk_i,
    input  wire logic                      reset_i,
    input  wire l2_trig_pkg::tio_meta_arr_t tio_meta_i,
    output l2_trig_pkg::pol_sectors_t      hpol_o,
    output l2_trig_pkg::pol_sectors_t      vpol_o
);
    import l2_trig_pkg::*;

    localparam int HALF   = `L2_NSECT / 2;
    localparam int BYTE_W = 2 * `L2_NREGION;

    wire pol_sectors_t hpol_map;
    wire pol_sectors_t vpol_map;

    // sectors 0..5 come from slots 5..0 of the first concentrator,
    // sectors 6..11 from slots 0..5 of the second
    for (genvar i = 0; i < `L2_NSECT; i++) begin : g_sect
        localparam int SLOT  = (i < HALF) ? (HALF - 1 - i) : (i - HALF);
        localparam int H_TIO = (i < HALF) ? 0 : 1;
        localparam int V_TIO = (i < HALF) ? 3 : 2;

        assign hpol_map.low[`L2_NREGION*i +: `L2_NREGION] =
            tio_meta_i[H_TIO][BYTE_W*SLOT +: `L2_NREGION];
        assign hpol_map.high[`L2_NREGION*i +: `L2_NREGION] =
            tio_meta_i[H_TIO][BYTE_W*SLOT + `L2_NREGION +: `L2_NREGION];
        assign vpol_map.low[`L2_NREGION*i +: `L2_NREGION] =
            tio_meta_i[V_TIO][BYTE_W*SLOT +: `L2_NREGION];
        assign vpol_map.high[`L2_NREGION*i +: `L2_NREGION] =
            tio_meta_i[V_TIO][BYTE_W*SLOT + `L2_NREGION +: `L2_NREGION];
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            hpol_o <= '0;
            vpol_o <= '0;
        end else begin
            hpol_o <= hpol_map;
            vpol_o <= vpol_map;
        end
    end

endmodule

`default_nettype wire

//--- src/l2_trig_pkg.sv
`default_nettype none

`include "l2_consts.svh"

package l2_trig_pkg;

    // raw words from one concentrator
    typedef logic [`L2_TRIG_W-1:0] tio_trig_t;
    typedef logic [`L2_META_W-1:0] tio_meta_t;

    // one word per concentrator, index is the concentrator number
    typedef tio_trig_t [`L2_NTIO-1:0] tio_trig_arr_t;
    typedef tio_meta_t [`L2_NTIO-1:0] tio_meta_arr_t;

    // 4 region bits per sector, sector i in bits 4i+3:4i
    typedef logic [`L2_SECT_W-1:0] sector_vec_t;

    // one bit per sector of a single polarization
    typedef logic [`L2_NSECT-1:0] sector_mask_t;

    // low and high region patterns of one polarization
    typedef struct packed {
        sector_vec_t low;
        sector_vec_t high;
    } pol_sectors_t;

    // per-sector pulses, hpol in 11:0 and vpol in 23:12
    typedef logic [`L2_NPOL*`L2_NSECT-1:0] scaler_vec_t;

    // trigger configuration from the register block
    typedef struct packed {
        logic                             rf_en;
        // 0 = and, 1 = or
        logic                             logic_type;
        // mask[pol][sector], set bit excludes the sector
        sector_mask_t [`L2_NPOL-1:0]      mask;
    } l2_cfg_t;

endpackage

`default_nettype wire

//--- src/l2_trigger_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_consts.svh"

module l2_trigger_top (
    input  wire logic                      clk_i,
    input  wire logic                      reset_i,
    input  wire l2_apb_pkg::apb_req_t      apb_req_i,
    output l2_apb_pkg::apb_rsp_t           apb_rsp_o,
    input  wire l2_trig_pkg::tio_trig_arr_t tio_trig_i,
    input  wire l2_trig_pkg::tio_meta_arr_t tio_meta_i,
    input  wire logic                      holdoff_i,
    input  wire logic                      dead_i,
    output l2_trig_pkg::tio_meta_arr_t     tio_meta_o,
    output l2_trig_pkg::scaler_vec_t       leveltwo_o,
    output logic                           trig_o
);
    import l2_trig_pkg::*;

    l2_cfg_t             cfg;
    pol_sectors_t        hpol_sectors;
    pol_sectors_t        vpol_sectors;
    logic [`L2_NPOL-1:0] pol_hit;
    sector_mask_t        hpol_scaler;
    sector_mask_t        vpol_scaler;

    l2_apb_regs u_regs (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .apb_req_i (apb_req_i),
        .apb_rsp_o (apb_rsp_o),
        .cfg_o     (cfg)
    );

    l2_sector_map u_map (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .tio_meta_i (tio_meta_i),
        .hpol_o     (hpol_sectors),
        .vpol_o     (vpol_sectors)
    );

    l2_coincidence u_hpol (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .sectors_i    (hpol_sectors),
        .mask_i       (cfg.mask[0]),
        .logic_type_i (cfg.logic_type),
        .rf_en_i      (cfg.rf_en),
        .pol_hit_o    (pol_hit[0]),
        .scaler_o     (hpol_scaler)
    );

    l2_coincidence u_vpol (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .sectors_i    (vpol_sectors),
        .mask_i       (cfg.mask[1]),
        .logic_type_i (cfg.logic_type),
        .rf_en_i      (cfg.rf_en),
        .pol_hit_o    (pol_hit[1]),
        .scaler_o     (vpol_scaler)
    );

    l2_master_trigger u_master (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .tio_trig_i (tio_trig_i),
        .rf_en_i    (cfg.rf_en),
        .pol_hit_i  (pol_hit),
        .holdoff_i  (holdoff_i),
        .dead_i     (dead_i),
        .trig_o     (trig_o)
    );

    l2_meta_align #(
        .DEPTH (`L2_RF_LATENCY)
    ) u_meta (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .tio_meta_i (tio_meta_i),
        .tio_meta_o (tio_meta_o)
    );

    // hpol scalers low, vpol high
    assign leveltwo_o = {vpol_scaler, hpol_scaler};

endmodule

`default_nettype wire

//--- tests/l2_trigger_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module l2_trigger_asserts (
    input wire logic                     clk_i,
    input wire logic                     reset_i,
    input wire logic                     holdoff_i,
    input wire logic                     dead_i,
    input wire logic                     trig_o,
    input wire l2_trig_pkg::scaler_vec_t leveltwo_o,
    input wire l2_apb_pkg::apb_rsp_t     apb_rsp_o
);
    // gated cycle never fires
    a_gate: assert property (@(posedge clk_i) disable iff (reset_i)
        (holdoff_i || dead_i) |=> !trig_o)
        else $error("trig_o high after holdoff or dead time");

    a_ready: assert property (@(posedge clk_i) apb_rsp_o.pready)
        else $error("pready dropped");

    // scalers are single-cycle pulses
    a_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        !(|(leveltwo_o & $past(leveltwo_o))))
        else $error("leveltwo_o bit high for two cycles");

    // outputs cleared once reset has been seen by an edge
    a_reset: assert property (@(posedge clk_i)
        (reset_i && $past(reset_i)) |-> (!trig_o && (leveltwo_o == '0)))
        else $error("outputs not cleared in reset");

endmodule

bind l2_trigger_top l2_trigger_asserts u_asserts (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .holdoff_i  (holdoff_i),
    .dead_i     (dead_i),
    .trig_o     (trig_o),
    .leveltwo_o (leveltwo_o),
    .apb_rsp_o  (apb_rsp_o)
);

`default_nettype wire

//--- tests/tb_l2_trigger.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_consts.svh"

module tb_l2_trigger;
    import l2_trig_pkg::*;
    import l2_apb_pkg::*;

    localparam int PHASE_CYCLES = 600;
    localparam int MAX_CYCLES   = 5000;

    logic          clk_i = 1'b0;
    logic          reset_i = 1'b1;
    apb_req_t      apb_req_i = '0;
    apb_rsp_t      apb_rsp_o;
    tio_trig_arr_t tio_trig_i = '0;
    tio_meta_arr_t tio_meta_i = '0;
    logic          holdoff_i = 1'b0;
    logic          dead_i = 1'b0;
    tio_meta_arr_t tio_meta_o;
    scaler_vec_t   leveltwo_o;
    logic          trig_o;

    // stimulus selection
    logic gen_meta = 1'b0;
    logic gen_trig = 1'b0;
    logic gen_gate = 1'b0;
    logic check_en = 1'b0;
    int   err_count = 0;
    int   cyc_count = 0;

    // model configuration, follows the register writes
    logic        m_rf = 1'b0;
    logic        m_or = 1'b0;
    logic [23:0] m_mask = '0;

    // model history, indexed by edge number modulo 8
    tio_meta_arr_t meta_h [8];
    logic          side_h [8];
    pol_sectors_t  hpol_h [8];
    pol_sectors_t  vpol_h [8];
    sector_mask_t  hit_q [2];
    sector_mask_t  hit_qq [2];
    logic [1:0]    polhit_q;
    int            edge_k = 8;
    int            por_cnt = 0;
    logic          exp_trig = 1'b0;
    scaler_vec_t   exp_l2 = '0;
    tio_meta_arr_t exp_meta = '0;

    l2_trigger_top l2_trigger_top_i (.*);

    initial begin
        forever #4 clk_i = ~clk_i;
    end

    function automatic logic [31:0] sparse32();
        return $urandom & $urandom & $urandom & $urandom;
    endfunction

    // sectors 0..5 from bytes 5..0 of tio a, sectors 6..11 from bytes 0..5 of tio b
    function automatic pol_sectors_t map_pol(tio_meta_arr_t m, int a, int b);
        pol_sectors_t ps;
        logic [7:0]   byte_v;
        for (int i = 0; i < 12; i++) begin
            byte_v = (i < 6) ? m[a][8*(5-i) +: 8] : m[b][8*(i-6) +: 8];
            ps.low[4*i +: 4]  = byte_v[3:0];
            ps.high[4*i +: 4] = byte_v[7:4];
        end
        return ps;
    endfunction

    function automatic sector_mask_t sect_hits(sector_vec_t lo, sector_vec_t hi,
                                               logic or_mode);
        sector_mask_t h;
        logic [3:0]   l;
        logic [3:0]   u;
        for (int i = 0; i < 12; i++) begin
            l = lo[4*i +: 4];
            u = hi[4*((i+1)%12) +: 4];
            h[i] = or_mode ? |(l | u) : |(l & u);
        end
        return h;
    endfunction

    task automatic abort_run();
        err_count++;
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // inputs change 1 ns after the edge
    task automatic drive_inputs();
        forever begin
            @(posedge clk_i);
            #1;
            for (int t = 0; t < `L2_NTIO; t++) begin
                tio_meta_i[t] = gen_meta ? {sparse32(), sparse32()} : '0;
                tio_trig_i[t] = gen_trig ? (8'(sparse32()) & 8'hc0) : '0;
            end
            holdoff_i = gen_gate && ($urandom % 8 == 0);
            dead_i    = gen_gate && ($urandom % 8 == 0);
        end
    endtask

    // reference model, reads inputs and model state at the edge
    always @(posedge clk_i) begin
        int           w;
        int           a;
        int           b;
        logic         por_ok;
        sector_mask_t nh0;
        sector_mask_t nh1;
        w = edge_k & 7;
        a = (edge_k - 2) & 7;
        b = (edge_k - 3) & 7;
        if (reset_i) begin
            for (int i = 0; i < 8; i++) begin
                meta_h[i] = '0;
                side_h[i] = 1'b0;
                hpol_h[i] = '0;
                vpol_h[i] = '0;
            end
            hit_q    = '{'0, '0};
            hit_qq   = '{'0, '0};
            polhit_q = '0;
            por_cnt  = 0;
            exp_trig = 1'b0;
            exp_l2   = '0;
            exp_meta = '0;
        end else begin
            por_ok = (por_cnt >= `L2_POR_CYCLES);
            if (!por_ok) begin
                por_cnt++;
            end
            meta_h[w] = tio_meta_i;
            side_h[w] = tio_trig_i[0][7] | tio_trig_i[1][7] | tio_trig_i[2][7] |
                        tio_trig_i[3][7] |
                        (m_rf & (tio_trig_i[0][6] | tio_trig_i[1][6] |
                                 tio_trig_i[2][6] | tio_trig_i[3][6]));
            hpol_h[w] = map_pol(tio_meta_i, 0, 1);
            vpol_h[w] = map_pol(tio_meta_i, 3, 2);
            exp_trig = !holdoff_i && !dead_i &&
                       (side_h[b] || (por_ok && (|polhit_q)));
            exp_meta = meta_h[b];
            exp_l2   = {hit_q[1] & ~hit_qq[1], hit_q[0] & ~hit_qq[0]};
            // sample k-2 stretched with sample k-3
            nh0 = sect_hits(hpol_h[a].low | hpol_h[b].low,
                            hpol_h[a].high | hpol_h[b].high, m_or);
            nh1 = sect_hits(vpol_h[a].low | vpol_h[b].low,
                            vpol_h[a].high | vpol_h[b].high, m_or);
            hit_qq   = hit_q;
            hit_q    = '{nh0, nh1};
            polhit_q = {m_rf && |(nh1 & ~m_mask[23:12]), m_rf && |(nh0 & ~m_mask[11:0])};
        end
        edge_k++;
    end

    always @(negedge clk_i) begin
        if (check_en) begin
            assert (trig_o === exp_trig) else begin
                $display("[FAIL] trig_o expected %h actual %h", exp_trig, trig_o);
                abort_run();
            end
            assert (leveltwo_o === exp_l2) else begin
                $display("[FAIL] leveltwo_o expected %h actual %h", exp_l2, leveltwo_o);
                abort_run();
            end
            assert (tio_meta_o === exp_meta) else begin
                $display("[FAIL] tio_meta_o expected %h actual %h", exp_meta, tio_meta_o);
                abort_run();
            end
        end
    end

    always @(posedge clk_i) begin
        cyc_count++;
        if (cyc_count >= MAX_CYCLES) begin
            $display("timeout: run went past the cycle limit");
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic apb_access(input logic wr, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(posedge clk_i);
        #1;
        apb_req_i = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk_i);
        #1;
        apb_req_i.penable = 1'b1;
        @(negedge clk_i);
        rdata = apb_rsp_o.prdata;
        err   = apb_rsp_o.pslverr;
        @(posedge clk_i);
        #1;
        apb_req_i = '0;
        // model sees the new value from the next edge on
        if (wr && addr == `L2_ADDR_CTRL) begin
            m_rf = wdata[0];
            m_or = wdata[1];
        end else if (wr && addr == `L2_ADDR_MASK) begin
            m_mask = wdata[23:0];
        end
    endtask

    task automatic apb_check(input logic wr, input logic [7:0] addr,
                             input logic [31:0] wdata, input logic [31:0] exp_rd,
                             input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_access(wr, addr, wdata, rd, err);
        assert (err === exp_err) else begin
            $display("[FAIL] pslverr expected %h actual %h", exp_err, err);
            abort_run();
        end
        assert (wr || rd === exp_rd) else begin
            $display("[FAIL] prdata expected %h actual %h", exp_rd, rd);
            abort_run();
        end
    endtask

    task automatic configure(input logic rf, input logic or_mode, input logic [23:0] mask);
        apb_check(1'b1, `L2_ADDR_CTRL, {30'd0, or_mode, rf}, '0, 1'b0);
        apb_check(1'b1, `L2_ADDR_MASK, {8'hff, mask}, '0, 1'b0);
    endtask

    // ctrl write overlaps the end of reset, so rf is on inside the power-on window
    task automatic reset_with_rf_on(input logic or_mode);
        @(posedge clk_i);
        #1;
        reset_i = 1'b1;
        repeat (3) @(posedge clk_i);
        #1;
        apb_req_i = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1,
                      paddr: `L2_ADDR_CTRL, pwdata: {30'd0, or_mode, 1'b1}};
        @(posedge clk_i);
        #1;
        reset_i           = 1'b0;
        apb_req_i.penable = 1'b1;
        m_rf   = 1'b0;
        m_or   = 1'b0;
        m_mask = '0;
        // write lands on the first edge out of reset
        @(posedge clk_i);
        #1;
        apb_req_i = '0;
        m_rf = 1'b1;
        m_or = or_mode;
    endtask

    initial begin
        void'($urandom(32'h0b82_2338));
        fork
            drive_inputs();
        join_none
        repeat (4) @(posedge clk_i);
        #1;
        reset_i  = 1'b0;
        check_en = 1'b1;

        // register access, unused bits and unmapped address
        apb_check(1'b1, `L2_ADDR_CTRL, 32'hffff_ffff, '0, 1'b0);
        apb_check(1'b0, `L2_ADDR_CTRL, '0, 32'h0000_0003, 1'b0);
        apb_check(1'b1, `L2_ADDR_MASK, 32'hffff_ffff, '0, 1'b0);
        apb_check(1'b0, `L2_ADDR_MASK, '0, 32'h00ff_ffff, 1'b0);
        apb_check(1'b1, 8'h08, 32'h0000_0000, '0, 1'b1);
        apb_check(1'b0, 8'h08, '0, 32'h0000_0000, 1'b1);
        apb_check(1'b0, `L2_ADDR_CTRL, '0, 32'h0000_0003, 1'b0);
        apb_check(1'b0, `L2_ADDR_MASK, '0, 32'h00ff_ffff, 1'b0);

        // and mode with random metadata
        configure(1'b1, 1'b0, 24'($urandom & $urandom));
        gen_meta = 1'b1;
        repeat (PHASE_CYCLES) @(posedge clk_i);

        // or mode, scaler pulses
        configure(1'b1, 1'b1, 24'($urandom & $urandom & $urandom));
        repeat (PHASE_CYCLES) @(posedge clk_i);

        // lf and aux alone, then rf disabled
        gen_meta = 1'b0;
        gen_trig = 1'b1;
        configure(1'b1, 1'b1, '0);
        repeat (PHASE_CYCLES / 2) @(posedge clk_i);
        gen_meta = 1'b1;
        configure(1'b0, 1'b1, '0);
        repeat (PHASE_CYCLES / 2) @(posedge clk_i);

        // holdoff and dead time
        gen_gate = 1'b1;
        configure(1'b1, 1'b1, 24'($urandom & $urandom));
        repeat (PHASE_CYCLES) @(posedge clk_i);

        // reset in the middle of traffic, power-on window
        gen_trig = 1'b0;
        gen_gate = 1'b0;
        reset_with_rf_on(1'b1);
        repeat (PHASE_CYCLES / 2) @(posedge clk_i);
        gen_trig = 1'b1;
        gen_gate = 1'b1;
        configure(1'b1, 1'b0, '0);
        repeat (PHASE_CYCLES / 2) @(posedge clk_i);

        // configuration changes while data flows
        for (int n = 0; n < 6; n++) begin
            configure($urandom % 4 != 0, 1'($urandom % 2), 24'($urandom & $urandom));
            repeat (PHASE_CYCLES / 6) @(posedge clk_i);
        end

        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
